// File: firDataPkg.sv
package firDataPkg;

	// samples are two's complement fractions, sign plus 17 fraction bits
	typedef logic signed [17:0] sampleT;

	// coefficient, sign plus 27 fraction bits
	typedef logic signed [27:0] coefT;

	// accumulator wide enough for the 46-bit product plus growth over a long program
	typedef logic signed [47:0] accT;

	// rounded and saturated filter output
	typedef logic signed [19:0] outT;

	// one input sample pair, x in the upper half
	typedef struct packed {
		sampleT x;	// in-phase
		sampleT y;	// quadrature
	} iqSampleT;

	// one output pair
	typedef struct packed {
		outT x;
		outT y;
	} iqOutT;

endpackage

// File: firProgPkg.sv
package firProgPkg;

	import firDataPkg::*;

	typedef logic [9:0] addrT;	// buffer and program memory address
	typedef logic [5:0] decT;	// decimation modulus

	// 32-bit instruction word
	// written as two half-words, coef[15:0] first, then flags and coef[27:16]
	typedef struct packed {
		logic wr;		// send accumulated sum to output
		logic ld;		// restart sum, reload data pointer
		logic sk;		// step data pointer back by two
		logic spare;	// reserved, reads back whatever was written
		coefT coef;
	} instrT;

	// static configuration, only changed while the engine is idle
	typedef struct packed {
		decT dec;		// samples consumed per output
		addrT ncoef;	// instruction count minus two
	} firCfgT;

endpackage

// File: firProgRam.sv
module firProgRam #(
	parameter int DEPTH_LOG2 = 10
) (
	input  logic              clk,
	input  logic              mrst,
	input  logic [15:0]       pdata,		// half-word program data
	input  logic              pwr,		// write strobe, advances half-word counter
	input  logic              prst,		// back to instruction 0, low half
	input  firProgPkg::addrT  fetchAddr,
	output firProgPkg::instrT instr
);
	import firProgPkg::*;

	logic [DEPTH_LOG2:0] hcnt;	// half-word counter, bit 0 picks the half
	logic [15:0] memLo [2**DEPTH_LOG2];
	logic [15:0] memHi [2**DEPTH_LOG2];
	instrT rdWord;	// memory read stage

	// programming side
	always_ff @(posedge clk)
	begin
		if (mrst | prst)
			hcnt <= '0;
		else if (pwr)
			hcnt <= hcnt + 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (pwr & ~hcnt[0])
			memLo[hcnt[DEPTH_LOG2:1]] <= pdata;	// coef[15:0]
		if (pwr & hcnt[0])
			memHi[hcnt[DEPTH_LOG2:1]] <= pdata;	// flags and coef[27:16]
	end

	// fetch side, memory cycle then output register
	always_ff @(posedge clk)
	begin
		rdWord <= {memHi[fetchAddr], memLo[fetchAddr]};
		instr <= rdWord;
	end

endmodule

// File: firSampleBuffer.sv
module firSampleBuffer #(
	parameter int DEPTH_LOG2 = 10
) (
	input  logic                 clk,
	input  logic                 mrst,
	input  firDataPkg::iqSampleT in,
	input  logic                 iv,			// one pair per strobe
	input  firProgPkg::addrT     readAddr,
	output firDataPkg::iqSampleT rdData,		// one cycle after readAddr
	output firProgPkg::addrT     wrAddr		// total samples written, mod depth
);
	import firDataPkg::*;

	iqSampleT mem [2**DEPTH_LOG2];	// x and y side by side, one word per pair

	// write counter doubles as sample count for the sequencer
	always_ff @(posedge clk)
	begin
		if (mrst)
			wrAddr <= '0;
		else if (iv)
			wrAddr <= wrAddr + 1'b1;
	end

	// ring storage
	// a read of the slot written in the same cycle returns old data,
	// the sequencer never reads a slot before wrAddr has moved past it
	always_ff @(posedge clk)
	begin
		if (iv)
			mem[wrAddr] <= in;
		rdData <= mem[readAddr];	// registered read
	end

endmodule

// File: firSequencer.sv
module firSequencer #(
	parameter int DEPTH_LOG2 = 10
) (
	input  logic               clk,
	input  logic               mrst,
	input  firProgPkg::firCfgT cfg,
	input  logic               oe,			// low stalls the instruction counter
	input  firProgPkg::addrT   wrAddr,		// sample count from the buffer
	input  firProgPkg::instrT  instr,		// 2 cycles after fetchAddr
	output firProgPkg::addrT   fetchAddr,
	output firProgPkg::addrT   readAddr,
	output firDataPkg::coefT   coef,		// aligned with buffer rdData
	output logic               first,
	output logic               last,
	output logic               rfd
);
	import firDataPkg::*;
	import firProgPkg::*;

	addrT base;						// samples claimed by started convolutions
	addrT baseNext;
	addrT ptrBase;					// newest sample of the convolution about to load
	logic [DEPTH_LOG2-1:0] avail;	// unprocessed samples
	logic [DEPTH_LOG2-1:0] excess;	// unprocessed beyond what the next start needs
	logic ready;
	logic full;
	logic busy;						// convolution being fetched
	logic tc;						// last instruction of the program issues next
	logic eof;
	logic start;
	logic run;						// a valid fetch slot is issued this cycle
	logic [2:0] vld;				// valid delay, vld[2] lines up with instr
	logic [1:0] startDly;
	coefT coefS3;					// stage after the instruction register
	logic ldS3;
	logic wrS3;

	// sample accounting
	assign excess = avail - {{(DEPTH_LOG2 - $bits(decT)){1'b0}}, cfg.dec};
	assign ready = ~excess[DEPTH_LOG2-1];					// at least dec samples waiting
	assign full = ready & (|excess[DEPTH_LOG2-2:4]);		// more than 15 extra
	assign rfd = ~full;

	// convolution control
	assign eof = tc & oe;
	assign start = oe & ready & (eof | ~busy);	// may overlap the previous final slot
	assign run = oe & (start | (busy & ~eof));
	assign baseNext = start ? base + addrT'(cfg.dec) : base;

	always_ff @(posedge clk)
	begin
		if (mrst)
		begin
			base <= '0;
			avail <= '0;
			fetchAddr <= '0;
			busy <= 1'b0;
			tc <= 1'b0;
			vld <= '0;
			startDly <= '0;
		end
		else
		begin
			base <= baseNext;
			avail <= wrAddr - baseNext;	// uses the advanced base, no stale start
			if (start)
				fetchAddr <= '0;
			else if (oe & busy)
				fetchAddr <= fetchAddr + 1'b1;
			if (oe)
			begin
				busy <= start | (busy & ~eof);
				tc <= busy & (fetchAddr == cfg.ncoef);	// one more slot follows
			end
			vld <= {vld[1:0], run};			// stalled cycles shift in no-ops
			startDly <= {startDly[0], start};
		end
	end

	// data pointer, instruction on cycle 3 and address on cycle 4
	always_ff @(posedge clk)
	begin
		if (startDly[1])
			ptrBase <= base - 1'b1;	// base has already advanced past this start
		if (mrst)
			readAddr <= '0;
		else if (vld[2])
			readAddr <= instr.ld ? ptrBase : readAddr - (instr.sk ? addrT'(2) : addrT'(1));
	end

	// coefficient and strobes, zeroed for no-op slots, then one more stage to meet rdData
	always_ff @(posedge clk)
	begin
		if (mrst | ~vld[2])
		begin
			coefS3 <= '0;
			ldS3 <= 1'b0;
			wrS3 <= 1'b0;
		end
		else
		begin
			coefS3 <= instr.coef;
			ldS3 <= instr.ld;
			wrS3 <= instr.wr;
		end
		if (mrst)
		begin
			coef <= '0;
			first <= 1'b0;
			last <= 1'b0;
		end
		else
		begin
			coef <= coefS3;	// cycle 5
			first <= ldS3;
			last <= wrS3;
		end
	end

endmodule

// File: firMac.sv
module firMac #(
	parameter int OUT_SHIFT = 26
) (
	input  logic               clk,
	input  logic               mrst,
	input  firDataPkg::coefT   coef,
	input  firDataPkg::sampleT din,
	input  logic               first,	// load the product, drop the old sum
	input  logic               last,	// deliver the sum 4 cycles on
	output firDataPkg::outT    dout,
	output logic               ov,
	output logic               ovf		// dout saturated, pulses with ov
);
	import firDataPkg::*;

	localparam int ACC_W = $bits(accT);
	localparam int OUT_W = $bits(outT);
	localparam int PROD_W = $bits(sampleT) + $bits(coefT);
	localparam accT HALF_LSB = accT'(1) <<< (OUT_SHIFT - 1);	// half an output lsb

	coefT coefR;
	sampleT dinR;
	logic signed [PROD_W-1:0] prod;
	accT acc;
	accT rnd;
	accT shifted;
	logic [ACC_W-OUT_W:0] top;	// bits that must all equal the sign
	logic over;
	outT sat;
	logic firstR;
	logic lastR;
	logic firstP;
	logic lastP;
	logic lastA;

	// round, then check range
	assign rnd = acc + HALF_LSB;
	assign shifted = rnd >>> OUT_SHIFT;
	assign top = shifted[ACC_W-1:OUT_W-1];
	assign over = ~((&top) | ~(|top));
	assign sat = shifted[ACC_W-1] ? {1'b1, {(OUT_W-1){1'b0}}} : {1'b0, {(OUT_W-1){1'b1}}};

	// datapath, no reset
	always_ff @(posedge clk)
	begin
		coefR <= coef;			// stage 1
		dinR <= din;
		prod <= coefR * dinR;	// stage 2, full 46-bit product
		if (firstP)
			acc <= accT'(prod);	// stage 3
		else
			acc <= acc + accT'(prod);
		if (lastA)
			dout <= over ? sat : shifted[OUT_W-1:0];	// stage 4
	end

	// strobes follow the data
	always_ff @(posedge clk)
	begin
		if (mrst)
		begin
			firstR <= 1'b0;
			lastR <= 1'b0;
			firstP <= 1'b0;
			lastP <= 1'b0;
			lastA <= 1'b0;
			ov <= 1'b0;
			ovf <= 1'b0;
		end
		else
		begin
			firstR <= first;
			lastR <= last;
			firstP <= firstR;
			lastP <= lastR;
			lastA <= lastP;
			ov <= lastA;
			ovf <= lastA & over;
		end
	end

endmodule

// File: firFilter.sv
module firFilter #(
	parameter int DEPTH_LOG2 = 10,	// buffer and program depth
	parameter int OUT_SHIFT = 26		// product bit where dout starts
) (
	input  logic                 clk,
	input  logic                 mrst,
	input  firDataPkg::iqSampleT in,
	input  logic                 iv,
	input  firProgPkg::firCfgT   cfg,
	input  logic                 oe,
	input  logic [15:0]          pdata,
	input  logic                 pwr,
	input  logic                 prst,
	output firDataPkg::iqOutT    out,
	output logic                 ov,
	output logic                 ovf,
	output logic                 rfd
);
	import firDataPkg::*;
	import firProgPkg::*;

	addrT fetchAddr;
	addrT readAddr;
	addrT wrAddr;
	instrT instr;
	iqSampleT rdData;
	coefT coef;		// shared by both channels
	logic first;
	logic last;
	outT doutX;
	outT doutY;
	logic ovfX;
	logic ovfY;

	firProgRam #(.DEPTH_LOG2(DEPTH_LOG2)) u_progRam (
		.clk(clk), .mrst(mrst), .pdata(pdata), .pwr(pwr), .prst(prst),
		.fetchAddr(fetchAddr), .instr(instr)
	);

	firSampleBuffer #(.DEPTH_LOG2(DEPTH_LOG2)) u_sampleBuf (
		.clk(clk), .mrst(mrst), .in(in), .iv(iv),
		.readAddr(readAddr), .rdData(rdData), .wrAddr(wrAddr)
	);

	firSequencer #(.DEPTH_LOG2(DEPTH_LOG2)) u_seq (
		.clk(clk), .mrst(mrst), .cfg(cfg), .oe(oe), .wrAddr(wrAddr), .instr(instr),
		.fetchAddr(fetchAddr), .readAddr(readAddr), .coef(coef),
		.first(first), .last(last), .rfd(rfd)
	);

	firMac #(.OUT_SHIFT(OUT_SHIFT)) u_macX (
		.clk(clk), .mrst(mrst), .coef(coef), .din(rdData.x), .first(first), .last(last),
		.dout(doutX), .ov(ov), .ovf(ovfX)
	);

	firMac #(.OUT_SHIFT(OUT_SHIFT)) u_macY (
		.clk(clk), .mrst(mrst), .coef(coef), .din(rdData.y), .first(first), .last(last),
		.dout(doutY), .ov(), .ovf(ovfY)	// ov identical to the x channel
	);

	assign out = '{x: doutX, y: doutY};
	assign ovf = ovfX | ovfY;

endmodule

// File: firTb.sv
module firTb;
	timeunit 1ns;
	timeprecision 1ps;
	import firDataPkg::*;
	import firProgPkg::*;

	typedef struct packed {
		iqOutT val;
		logic ovf;
	} resultT;

	// reset 28, t1 10, prefill 1025, t2 70, t3 180, t4 180, t5 70, t6 225
	localparam int PLAN_CYCLES = 28 + 10 + 1025 + 70 + 180 + 180 + 70 + 225;
	localparam int LIMIT = PLAN_CYCLES * 6 / 5;	// 20% margin

	logic clk, mrst, iv, oe, pwr, prst;
	logic ov, ovf, rfd;
	iqSampleT in;
	firCfgT cfg;
	logic [15:0] pdata;
	iqOutT out;

	logic signed [27:0] pCoef [16];	// program as the model sees it
	logic pLd [16];
	logic pWr [16];
	logic pSk [16];
	int nInstr;
	sampleT mx [1024];	// mirror of the ring buffer
	sampleT my [1024];
	int wp, nSent, nConv;
	resultT expQ [$];	// results still owed by the DUT
	resultT head;
	logic [31:0] lcgState = 32'ha656_875c;
	int errors, checks, outCount, ovfCount, cycles, outStart, errStart;
	logic quiet;	// no ov allowed while set

	firFilter #(.DEPTH_LOG2(10), .OUT_SHIFT(26)) u_dut (
		.clk(clk), .mrst(mrst), .in(in), .iv(iv), .cfg(cfg), .oe(oe),
		.pdata(pdata), .pwr(pwr), .prst(prst), .out(out), .ov(ov), .ovf(ovf), .rfd(rfd)
	);

	always #50 clk = ~clk;

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= LIMIT)
		begin
			$display("timeout after %0d cycles, run did not finish", cycles);
			$display("TEST FAIL");
			$finish;
		end
	end

	// output checker on the falling edge, half a cycle after the outputs move
	always @(negedge clk)
	begin
		if (!mrst && ov)
		begin
			outCount++;
			ovfCount += ovf;
			checks++;
			assert (expQ.size() != 0)
			else
			begin
				$display("output at %0t while no result was pending", $time);
				errors++;
			end
			if (expQ.size() != 0)
			begin
				head = expQ.pop_front();
				checks += 3;
				assert (out.x === head.val.x)
				else
				begin
					$display("mismatch at %0t: out.x expected %0d got %0d",
						$time, head.val.x, out.x);
					errors++;
				end
				assert (out.y === head.val.y)
				else
				begin
					$display("mismatch at %0t: out.y expected %0d got %0d",
						$time, head.val.y, out.y);
					errors++;
				end
				assert (ovf === head.ovf)
				else
				begin
					$display("mismatch at %0t: ovf expected %0b got %0b",
						$time, head.ovf, ovf);
					errors++;
				end
			end
		end
		assert (!(ovf && !ov))
		else
		begin
			$display("ovf at %0t without ov", $time);
			errors++;
		end
		assert (!(quiet && ov))
		else
		begin
			$display("ov at %0t while stalled", $time);
			errors++;
		end
	end

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	function automatic sampleT sampleRand();
		logic [31:0] r;
		r = nextRand();
		return r[31:14];
	endfunction

	function automatic void scaleOut(input longint s, output outT v, output logic sat);
		longint r;
		r = (s + 64'sd33554432) >>> 26;	// add half an output lsb and drop 26 bits
		sat = (r > 524287) || (r < -524288);
		v = (r > 524287) ? 20'sd524287 : (r < -524288) ? -20'sd524288 : outT'(r);
	endfunction

	// convolution ending at sample number base (first sample is number 1)
	function automatic void pushExpected(int base);
		longint sx, sy;
		int ptr;
		logic satX, satY;
		resultT r;
		sx = 0;
		sy = 0;
		ptr = base - 1;
		for (int k = 0; k < nInstr; k++)
		begin
			if (k > 0)
				ptr -= pSk[k] ? 2 : 1;	// later taps step back before reading
			sx += longint'(pCoef[k]) * longint'(mx[ptr & 1023]);
			sy += longint'(pCoef[k]) * longint'(my[ptr & 1023]);
		end
		scaleOut(sx, r.val.x, satX);
		scaleOut(sy, r.val.y, satY);
		r.ovf = satX | satY;
		expQ.push_back(r);
	endfunction

	task automatic tick();
		@(posedge clk);
		#5;	// inputs change clear of the edge
	endtask

	task automatic resetDut();
		mrst = 1'b1;
		repeat (3) tick();
		mrst = 1'b0;
		wp = 0;
		nSent = 0;
		nConv = 0;
	endtask

	task automatic randomProgram(int n, logic skAlt);
		logic [31:0] r;
		nInstr = n;
		for (int k = 0; k < n; k++)
		begin
			r = nextRand();
			pCoef[k] = 28'($signed(r) >>> 7);	// 25-bit range keeps sums unsaturated
			pLd[k] = (k == 0);
			pWr[k] = (k == n - 1);
			pSk[k] = skAlt & k[0];
		end
	endtask

	task automatic loadProgram();
		logic [31:0] word;
		cfg.ncoef = addrT'(nInstr - 2);
		prst = 1'b1;
		tick();
		prst = 1'b0;
		pwr = 1'b1;
		for (int k = 0; k < nInstr; k++)
		begin
			word = {pWr[k], pLd[k], pSk[k], 1'b0, pCoef[k]};
			pdata = word[15:0];	// low half first
			tick();
			pdata = word[31:16];
			tick();
		end
		pwr = 1'b0;
	endtask

	task automatic sendSample(sampleT x, sampleT y, int gap);
		in.x = x;
		in.y = y;
		iv = 1'b1;
		mx[wp & 1023] = x;
		my[wp & 1023] = y;
		wp++;
		nSent++;
		if (nSent % cfg.dec == 0)
		begin
			nConv++;
			pushExpected(nSent);
		end
		tick();
		iv = 1'b0;
		repeat (gap) tick();
	endtask

	task automatic checkLevel(string name, logic actual, logic expected);
		checks++;
		assert (actual === expected)
		else
		begin
			$display("mismatch at %0t: %s expected %0b got %0b", $time, name, expected, actual);
			errors++;
		end
	endtask

	task automatic waitDrain();
		int n;
		n = 0;
		while (expQ.size() != 0 && n < 400)
		begin
			tick();
			n++;
		end
		checks++;
		assert (expQ.size() == 0)
		else
		begin
			$display("%0d results never came out", expQ.size());
			errors++;
			expQ.delete();
		end
	endtask

	task automatic beginTest();
		outStart = outCount;
		errStart = errors;
	endtask

	task automatic endTest(int num, string name);
		waitDrain();
		repeat (20) tick();	// any extra ov is flagged by the checker
		checks++;
		assert (outCount - outStart == nConv)
		else
		begin
			$display("test %0d gave %0d outputs for %0d convolutions",
				num, outCount - outStart, nConv);
			errors++;
		end
		$display("test %0d %s: %0d outputs, %0d errors", num, name, outCount - outStart,
			errors - errStart);
	endtask

	initial
	begin
		clk = 1'b0;
		mrst = 1'b1;
		in = '0;
		iv = 1'b0;
		cfg.dec = 6'd1;
		cfg.ncoef = '0;
		oe = 1'b1;
		pdata = '0;
		pwr = 1'b0;
		prst = 1'b0;
		quiet = 1'b0;
		errors = 0;
		checks = 0;
		outCount = 0;
		ovfCount = 0;
		cycles = 0;
		#5;
		resetDut();

		beginTest();
		repeat (8)
		begin
			checkLevel("ov", ov, 1'b0);
			checkLevel("ovf", ovf, 1'b0);
			checkLevel("rfd", rfd, 1'b1);
			tick();
		end
		endTest(1, "reset state");

		// fill the whole ring so early taps never read unknowns
		// each address gets its own pair so address faults change the sums
		oe = 1'b0;
		for (int i = 0; i < 1024; i++)
		begin
			mx[i] = sampleT'({i[9:0], ~i[9:2]});
			my[i] = sampleT'({~i[9:0], i[7:0]});
			in.x = mx[i];
			in.y = my[i];
			iv = 1'b1;
			tick();
		end
		iv = 1'b0;
		oe = 1'b1;

		resetDut();	// half gain with one sample per output
		beginTest();
		cfg.dec = 6'd1;
		nInstr = 2;
		pCoef[0] = 28'sh400_0000;
		pLd[0] = 1'b1;
		pWr[0] = 1'b0;
		pSk[0] = 1'b0;
		pCoef[1] = '0;
		pLd[1] = 1'b0;
		pWr[1] = 1'b1;
		pSk[1] = 1'b0;
		loadProgram();
		repeat (16) sendSample(sampleRand(), sampleRand(), 1);
		endTest(2, "half gain");

		resetDut();
		beginTest();
		cfg.dec = 6'd2;
		randomProgram(8, 1'b0);
		loadProgram();
		repeat (24) sendSample(sampleRand(), sampleRand(), nextRand() % 4);
		endTest(3, "random taps");

		resetDut();
		beginTest();
		randomProgram(8, 1'b1);	// skip on odd taps
		loadProgram();
		repeat (24) sendSample(sampleRand(), sampleRand(), nextRand() % 4);
		endTest(4, "skip taps");

		resetDut();
		beginTest();
		cfg.dec = 6'd1;
		randomProgram(4, 1'b0);
		for (int k = 0; k < 4; k++)
			pCoef[k] = 28'sh7ff_ffff;	// near +1
		loadProgram();
		repeat (6) sendSample(18'sh1ffff, -18'sh20000, 1);	// full scale both signs
		waitDrain();
		checks++;
		assert (ovfCount > 0)
		else
		begin
			$display("no overflow flagged");
			errors++;
		end
		endTest(5, "saturation");

		resetDut();
		beginTest();
		cfg.dec = 6'd2;
		randomProgram(4, 1'b0);
		loadProgram();
		repeat (6) sendSample(sampleRand(), sampleRand(), 1);
		oe = 1'b0;	// may land mid convolution
		repeat (34) sendSample(sampleRand(), sampleRand(), 0);
		repeat (15) tick();	// already fetched slots finish
		checkLevel("rfd", rfd, 1'b0);
		quiet = 1'b1;
		repeat (40) tick();
		quiet = 1'b0;
		oe = 1'b1;
		endTest(6, "output stall");

		$display("tests 6, checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// File: files.f
firDataPkg.sv
firProgPkg.sv
firProgRam.sv
firSampleBuffer.sv
firSequencer.sv
firMac.sv
firFilter.sv
firTb.sv

// File: Bender.yml
package:
  name: firFilter

sources:
  - firDataPkg.sv
  - firProgPkg.sv
  - firProgRam.sv
  - firSampleBuffer.sv
  - firSequencer.sv
  - firMac.sv
  - firFilter.sv
  - target: simulation
    files:
      - firTb.sv
